//--- hw/alu.sv
module alu (
  input  mipsCorePkg::wordT  a,
  input  mipsCorePkg::wordT  b,
  input  mipsCorePkg::aluOpT op,
  output mipsCorePkg::wordT  result,
  output logic               zero
);

  // signed compare for slt
  logic lessThan;

  assign lessThan = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      mipsCorePkg::ADD: begin
        result = a + b;
      end
      mipsCorePkg::SUB: begin
        result = a - b;
      end
      mipsCorePkg::AND: begin
        result = a & b;
      end
      mipsCorePkg::OR: begin
        result = a | b;
      end
      mipsCorePkg::SLT: begin
        result = {31'd0, lessThan};
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // beq uses this after sub
  assign zero = (result == '0);

endmodule

//--- hw/coreSettings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// pc value taken on reset, first fetch address
`define RESET_VECTOR 32'h0000_0000

// data memory word address width, 128 words
`define DADDR_W 7

// architectural register count
`define REG_COUNT 32

`endif

//--- hw/instrDecoder.sv
module instrDecoder (
  input  mipsIsaPkg::opcodeT opcode,
  input  mipsIsaPkg::functT  funct,
  output logic               regDst,
  output logic               aluSrc,
  output logic               regWrite,
  output mipsCorePkg::aluOpT aluOp,
  output mipsCorePkg::wbSelT wbSel,
  output logic               memRead,
  output logic               memWrite,
  output logic               isBranch,
  output logic               isJump,
  output mipsCorePkg::pcSelT pcKind
);

  always_comb begin
    // defaults give a no-op
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    regWrite = 1'b0;
    aluOp    = mipsCorePkg::ADD;
    wbSel    = mipsCorePkg::WB_ALU;
    memRead  = 1'b0;
    memWrite = 1'b0;
    isBranch = 1'b0;
    isJump   = 1'b0;
    pcKind   = mipsCorePkg::SEQ;
    case (opcode)
      mipsIsaPkg::RTYPE: begin
        // funct picks the op into rd
        regDst   = 1'b1;
        regWrite = 1'b1;
        case (funct)
          mipsIsaPkg::ADD: aluOp = mipsCorePkg::ADD;
          mipsIsaPkg::SUB: aluOp = mipsCorePkg::SUB;
          mipsIsaPkg::AND: aluOp = mipsCorePkg::AND;
          mipsIsaPkg::OR:  aluOp = mipsCorePkg::OR;
          mipsIsaPkg::SLT: aluOp = mipsCorePkg::SLT;
          mipsIsaPkg::JR: begin
            // target is the rs value
            regWrite = 1'b0;
            pcKind   = mipsCorePkg::JREG;
          end
          default: regWrite = 1'b0;
        endcase
      end
      mipsIsaPkg::ADDI: begin
        aluSrc   = 1'b1;
        regWrite = 1'b1;
      end
      mipsIsaPkg::LW: begin
        // address is rs + imm
        aluSrc   = 1'b1;
        regWrite = 1'b1;
        memRead  = 1'b1;
        wbSel    = mipsCorePkg::WB_MEM;
      end
      mipsIsaPkg::SW: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
      end
      mipsIsaPkg::BEQ: begin
        // zero flag of rs minus rt decides
        aluOp    = mipsCorePkg::SUB;
        isBranch = 1'b1;
      end
      mipsIsaPkg::J: begin
        pcKind = mipsCorePkg::JUMP;
      end
      mipsIsaPkg::JAL: begin
        // jump and link into r31
        regWrite = 1'b1;
        isJump   = 1'b1;
        wbSel    = mipsCorePkg::WB_LINK;
        pcKind   = mipsCorePkg::JUMP;
      end
      default: begin
        // unknown opcode keeps the no-op defaults
      end
    endcase
  end

endmodule

//--- hw/mipsCore.sv
`include "coreSettings.svh"

module mipsCore (
  input  logic                   clk,
  input  logic                   rst,
  output mipsCorePkg::wordT      instrAddr,
  input  mipsCorePkg::wordT      instr,
  output logic [`DADDR_W-1:0]    dataAddr,
  output mipsCorePkg::wordT      dataWr,
  input  mipsCorePkg::wordT      dataRd,
  output logic                   ceN,
  output logic                   weN,
  output logic                   wbValid,
  output mipsIsaPkg::regAddrT    wbAddr,
  output mipsCorePkg::wordT      wbData
);

  // ======================================================================
  // instruction fields
  // ======================================================================
  mipsIsaPkg::opcodeT     opcode;
  mipsIsaPkg::functT      funct;
  mipsIsaPkg::regAddrT    rs;
  mipsIsaPkg::regAddrT    rt;
  mipsIsaPkg::regAddrT    rd;
  mipsIsaPkg::immT        imm;
  mipsIsaPkg::jumpTargetT jumpIndex;
  mipsCorePkg::wordT      immExt;

  assign opcode    = mipsIsaPkg::opcodeT'(instr[31:26]);
  assign funct     = mipsIsaPkg::functT'(instr[5:0]);
  assign rs        = instr[25:21];
  assign rt        = instr[20:16];
  assign rd        = instr[15:11];
  assign imm       = instr[15:0];
  assign jumpIndex = instr[25:0];
  // sign extension
  assign immExt    = {{16{imm[15]}}, imm};

  // decoder controls
  logic               regDst;
  logic               aluSrc;
  logic               regWrite;
  logic               memRead;
  logic               memWrite;
  logic               isBranch;
  logic               isJump;
  mipsCorePkg::aluOpT aluOp;
  mipsCorePkg::wbSelT wbSel;
  mipsCorePkg::pcSelT pcKind;
  mipsCorePkg::pcSelT pcSel;

  // datapath
  mipsCorePkg::wordT rsData;
  mipsCorePkg::wordT rtData;
  mipsCorePkg::wordT aluB;
  mipsCorePkg::wordT aluResult;
  logic              aluZero;
  mipsCorePkg::wordT linkAddr;

  // low through reset, high from the first edge after release
  logic run;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      run <= 1'b0;
    end else begin
      run <= 1'b1;
    end
  end

  instrDecoder u_instrDecoder (
    .opcode   (opcode),
    .funct    (funct),
    .regDst   (regDst),
    .aluSrc   (aluSrc),
    .regWrite (regWrite),
    .aluOp    (aluOp),
    .wbSel    (wbSel),
    .memRead  (memRead),
    .memWrite (memWrite),
    .isBranch (isBranch),
    .isJump   (isJump),
    .pcKind   (pcKind)
  );

  // taken beq overrides the decoder's kind
  assign pcSel = (isBranch && aluZero) ? mipsCorePkg::BRANCH : pcKind;

  progCounter u_progCounter (
    .clk          (clk),
    .rst          (rst),
    .pcSel        (pcSel),
    .branchOffset (immExt),
    .jumpIndex    (jumpIndex),
    .regTarget    (rsData),
    .run          (run),
    .pc           (instrAddr),
    .linkAddr     (linkAddr)
  );

  // ======================================================================
  // register file and write-back
  // ======================================================================

  // jal is the only jump that links, always to r31
  assign wbAddr  = isJump ? 5'd31 : (regDst ? rd : rt);
  assign wbValid = run && regWrite;

  always_comb begin
    case (wbSel)
      mipsCorePkg::WB_MEM:  wbData = dataRd;
      mipsCorePkg::WB_LINK: wbData = linkAddr;
      default:              wbData = aluResult;
    endcase
  end

  regFile u_regFile (
    .clk     (clk),
    .rst     (rst),
    .we      (wbValid),
    .rdAddrA (rs),
    .rdAddrB (rt),
    .wrAddr  (wbAddr),
    .wrData  (wbData),
    .rdDataA (rsData),
    .rdDataB (rtData)
  );

  // immediate for addi, lw, sw
  assign aluB = aluSrc ? immExt : rtData;

  alu u_alu (
    .a      (rsData),
    .b      (aluB),
    .op     (aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  // ======================================================================
  // data memory port
  // ======================================================================

  // word address, byte offset dropped
  assign dataAddr = aluResult[`DADDR_W+1:2];
  assign dataWr   = rtData;
  // strobes stay idle until run
  assign ceN      = !(run && (memRead || memWrite));
  assign weN      = !(run && memWrite);

endmodule

//--- hw/mipsCorePkg.sv
package mipsCorePkg;

  // datapath word, registers and memory data
  typedef logic [31:0] wordT;

  // alu operation, already resolved from opcode and funct
  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    SLT
  } aluOpT;

  // write-back source
  // link is pc+8 for jal
  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_LINK
  } wbSelT;

  // next-pc source
  typedef enum logic [1:0] {
    SEQ,
    BRANCH,
    JUMP,
    JREG
  } pcSelT;

endpackage

//--- hw/mipsIsaPkg.sv
package mipsIsaPkg;

  // ======================================================================
  // instruction fields
  // ======================================================================

  // rs, rt, rd index
  typedef logic [4:0] regAddrT;

  // i-type immediate, sign extended in the core
  typedef logic [15:0] immT;

  // j-type word index, bits 25:0
  typedef logic [25:0] jumpTargetT;

  // ======================================================================
  // encodings
  // ======================================================================

  // primary opcode, bits 31:26
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    JAL   = 6'h03,
    BEQ   = 6'h04,
    ADDI  = 6'h08,
    LW    = 6'h23,
    SW    = 6'h2b
  } opcodeT;

  // r-type function field, bits 5:0
  // jr shares the r-type opcode
  typedef enum logic [5:0] {
    JR  = 6'h08,
    ADD = 6'h20,
    SUB = 6'h22,
    AND = 6'h24,
    OR  = 6'h25,
    SLT = 6'h2a
  } functT;

endpackage

//--- hw/progCounter.sv
`include "coreSettings.svh"

module progCounter (
  input  logic                   clk,
  input  logic                   rst,
  input  mipsCorePkg::pcSelT     pcSel,
  input  mipsCorePkg::wordT      branchOffset,
  input  mipsIsaPkg::jumpTargetT jumpIndex,
  input  mipsCorePkg::wordT      regTarget,
  input  logic                   run,
  output mipsCorePkg::wordT      pc,
  output mipsCorePkg::wordT      linkAddr
);

  mipsCorePkg::wordT pcReg;
  mipsCorePkg::wordT pcPlus4;
  mipsCorePkg::wordT nextPc;

  assign pcPlus4  = pcReg + 32'd4;
  // jal link, one slot past pc+4
  assign linkAddr = pcReg + 32'd8;
  assign pc       = pcReg;

  // ======================================================================
  // next-pc select
  // ======================================================================
  always_comb begin
    case (pcSel)
      // offset is in words
      mipsCorePkg::BRANCH: nextPc = pcPlus4 + {branchOffset[29:0], 2'b00};
      // region bits from pc+4
      mipsCorePkg::JUMP:   nextPc = {pcPlus4[31:28], jumpIndex, 2'b00};
      mipsCorePkg::JREG:   nextPc = regTarget;
      default:             nextPc = pcPlus4;
    endcase
  end

  // pc holds until the core runs
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pcReg <= `RESET_VECTOR;
    end else if (run) begin
      pcReg <= nextPc;
    end
  end

endmodule

//--- hw/regFile.sv
`include "coreSettings.svh"

module regFile (
  input  logic                clk,
  input  logic                rst,
  input  logic                we,
  input  mipsIsaPkg::regAddrT rdAddrA,
  input  mipsIsaPkg::regAddrT rdAddrB,
  input  mipsIsaPkg::regAddrT wrAddr,
  input  mipsCorePkg::wordT   wrData,
  output mipsCorePkg::wordT   rdDataA,
  output mipsCorePkg::wordT   rdDataB
);

  mipsCorePkg::wordT regs [`REG_COUNT];

  // all registers cleared on reset
  // r0 never takes a write
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wrAddr != '0)) begin
      regs[wrAddr] <= wrData;
    end
  end

  // ======================================================================
  // combinational read ports
  // ======================================================================

  // r0 forced to zero
  assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
  assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

//--- mipsCore.f
+incdir+hw
hw/mipsIsaPkg.sv
hw/mipsCorePkg.sv
hw/instrDecoder.sv
hw/progCounter.sv
hw/regFile.sv
hw/alu.sv
hw/mipsCore.sv
tests/tbMipsCore.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f mipsCore.f --top-module tbMipsCore -o simMipsCore
output=$(./obj_dir/simMipsCore)
echo "$output"

if echo "$output" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1

//--- tests/tbMipsCore.sv
`include "coreSettings.svh"

module tbMipsCore;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumTests   = 6;
  localparam int InstrWords = 256;
  localparam int DataWords  = 1 << `DADDR_W;

  logic                  clk;
  logic                  rst;
  mipsCorePkg::wordT     instrAddr;
  mipsCorePkg::wordT     instr;
  logic [`DADDR_W-1:0]   dataAddr;
  mipsCorePkg::wordT     dataWr;
  mipsCorePkg::wordT     dataRd;
  logic                  ceN;
  logic                  weN;
  logic                  wbValid;
  mipsIsaPkg::regAddrT   wbAddr;
  mipsCorePkg::wordT     wbData;

  // memory models and the ISA-level shadow state
  mipsCorePkg::wordT imem [InstrWords];
  mipsCorePkg::wordT dmem [DataWords];
  mipsCorePkg::wordT shadowMem [DataWords];
  mipsCorePkg::wordT shadowRegs [32];
  mipsCorePkg::wordT shadowPc;
  logic              reloadMem;
  logic [31:0]       lfsrState;
  int                progLen;
  int                errorCount;
  int                errorsAtStart;
  int                testCount;

  mipsCore u_mipsCore (
    .clk       (clk),
    .rst       (rst),
    .instrAddr (instrAddr),
    .instr     (instr),
    .dataAddr  (dataAddr),
    .dataWr    (dataWr),
    .dataRd    (dataRd),
    .ceN       (ceN),
    .weN       (weN),
    .wbValid   (wbValid),
    .wbAddr    (wbAddr),
    .wbData    (wbData)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ======================================================================
  // memory models
  // ======================================================================

  // word-indexed fetch, same-cycle answer
  assign instr  = imem[instrAddr[9:2]];
  assign dataRd = dmem[dataAddr];

  // idle data word, tagged with its own address
  function automatic mipsCorePkg::wordT dataFill(int idx);
    return {16'hd0da, 9'd0, 7'(idx)};
  endfunction

  // reload during reset, else write on ceN and weN low
  always @(posedge clk) begin
    if (reloadMem) begin
      for (int i = 0; i < DataWords; i++) begin
        dmem[7'(i)] <= dataFill(i);
      end
    end else if (!ceN && !weN) begin
      dmem[dataAddr] <= dataWr;
    end
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] lfsrBits(int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      bits      = {bits[30:0], fb};
    end
    return bits;
  endfunction

  // ======================================================================
  // assembler helpers
  // ======================================================================
  function automatic mipsCorePkg::wordT encR(mipsIsaPkg::functT f, mipsIsaPkg::regAddrT rd,
                                             mipsIsaPkg::regAddrT rs, mipsIsaPkg::regAddrT rt);
    return {6'h00, rs, rt, rd, 5'd0, 6'(f)};
  endfunction

  // op rt, imm(rs)
  function automatic mipsCorePkg::wordT encI(mipsIsaPkg::opcodeT op, mipsIsaPkg::regAddrT rt,
                                             mipsIsaPkg::regAddrT rs, mipsIsaPkg::immT imm);
    return {6'(op), rs, rt, imm};
  endfunction

  // idx is the word index of the target
  function automatic mipsCorePkg::wordT encJ(mipsIsaPkg::opcodeT op, int idx);
    return {6'(op), 26'(idx)};
  endfunction

  task automatic emit(mipsCorePkg::wordT w);
    imem[8'(progLen)] = w;
    progLen++;
  endtask

  // ======================================================================
  // checking
  // ======================================================================
  task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
      errorCount++;
    end
  endtask

  // core held: pc at reset vector, no strobes, no write-back
  task automatic checkIdle();
    checkValue("instrAddr", instrAddr, `RESET_VECTOR);
    checkValue("ceN", 32'(ceN), 32'd1);
    checkValue("weN", 32'(weN), 32'd1);
    checkValue("wbValid", 32'(wbValid), 32'd0);
  endtask

  // one instruction on the shadow model, compared mid-cycle
  task automatic executeStep();
    mipsCorePkg::wordT   ins;
    mipsCorePkg::wordT   a;
    mipsCorePkg::wordT   b;
    mipsCorePkg::wordT   se;
    mipsCorePkg::wordT   addr;
    mipsCorePkg::wordT   expData;
    mipsCorePkg::wordT   nextPc;
    mipsIsaPkg::regAddrT dst;
    logic                expWb;
    logic                expCe;
    logic                expWe;
    #40;
    ins     = imem[shadowPc[9:2]];
    a       = shadowRegs[ins[25:21]];
    b       = shadowRegs[ins[20:16]];
    se      = {{16{ins[15]}}, ins[15:0]};
    addr    = a + se;
    expData = '0;
    dst     = '0;
    expWb   = 1'b0;
    expCe   = 1'b1;
    expWe   = 1'b1;
    nextPc  = shadowPc + 32'd4;
    case (ins[31:26])
      mipsIsaPkg::RTYPE: begin
        dst   = ins[15:11];
        expWb = 1'b1;
        case (ins[5:0])
          mipsIsaPkg::ADD: expData = a + b;
          mipsIsaPkg::SUB: expData = a - b;
          mipsIsaPkg::AND: expData = a & b;
          mipsIsaPkg::OR:  expData = a | b;
          mipsIsaPkg::SLT: expData = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          mipsIsaPkg::JR: begin
            expWb  = 1'b0;
            nextPc = a;
          end
          default: expWb = 1'b0;
        endcase
      end
      mipsIsaPkg::ADDI: begin
        dst     = ins[20:16];
        expWb   = 1'b1;
        expData = addr;
      end
      mipsIsaPkg::LW: begin
        dst     = ins[20:16];
        expWb   = 1'b1;
        expCe   = 1'b0;
        expData = shadowMem[addr[8:2]];
      end
      mipsIsaPkg::SW: begin
        expCe = 1'b0;
        expWe = 1'b0;
      end
      mipsIsaPkg::BEQ: begin
        // offset in words from pc+4
        if (a == b) begin
          nextPc = shadowPc + 32'd4 + {se[29:0], 2'b00};
        end
      end
      mipsIsaPkg::J: begin
        nextPc = {nextPc[31:28], ins[25:0], 2'b00};
      end
      mipsIsaPkg::JAL: begin
        dst     = 5'd31;
        expWb   = 1'b1;
        expData = shadowPc + 32'd8;
        nextPc  = {nextPc[31:28], ins[25:0], 2'b00};
      end
      default: expWb = 1'b0;
    endcase
    checkValue("instrAddr", instrAddr, shadowPc);
    checkValue("ceN", 32'(ceN), 32'(expCe));
    checkValue("weN", 32'(weN), 32'(expWe));
    checkValue("wbValid", 32'(wbValid), 32'(expWb));
    if (expWb) begin
      checkValue("wbAddr", 32'(wbAddr), 32'(dst));
      checkValue("wbData", wbData, expData);
    end
    if (!expCe) begin
      checkValue("dataAddr", 32'(dataAddr), 32'(addr[8:2]));
    end
    if (!expWe) begin
      checkValue("dataWr", dataWr, b);
      shadowMem[addr[8:2]] = b;
    end
    // r0 is never written
    if (expWb && (dst != 5'd0)) begin
      shadowRegs[dst] = expData;
    end
    shadowPc = nextPc;
    @(posedge clk);
    #5;
  endtask

  task automatic runSteps(int n);
    repeat (n) executeStep();
  endtask

  // ======================================================================
  // test framing
  // ======================================================================

  // reset on, idle memories, shadow cleared
  task automatic beginTest();
    errorsAtStart = errorCount;
    rst           = 1'b0;
    reloadMem     = 1'b1;
    progLen       = 0;
    // every idle slot jumps to itself
    for (int i = 0; i < InstrWords; i++) begin
      imem[8'(i)] = encJ(mipsIsaPkg::J, i);
    end
    for (int i = 0; i < DataWords; i++) begin
      shadowMem[7'(i)] = dataFill(i);
    end
    for (int i = 0; i < 32; i++) begin
      shadowRegs[5'(i)] = '0;
    end
    shadowPc = `RESET_VECTOR;
  endtask

  // two cycles low, then one idle cycle before run
  task automatic releaseReset();
    repeat (2) begin
      #40;
      checkIdle();
      @(posedge clk);
      #5;
    end
    rst       = 1'b1;
    reloadMem = 1'b0;
    #40;
    checkIdle();
    @(posedge clk);
    #5;
  endtask

  task automatic endTest(string name);
    testCount++;
    if (errorCount == errorsAtStart) begin
      $display("test %-8s passed", name);
    end else begin
      $display("test %-8s failed, %0d errors", name, errorCount - errorsAtStart);
    end
  endtask

  // ======================================================================
  // directed tests
  // ======================================================================

  // sw first, its strobes must stay off until run
  task automatic testReset();
    beginTest();
    emit(encI(mipsIsaPkg::SW, 5'd0, 5'd0, 16'd4));
    emit(encI(mipsIsaPkg::ADDI, 5'd1, 5'd0, 16'd5));
    releaseReset();
    runSteps(2);
    endTest("reset");
  endtask

  task automatic testArith();
    beginTest();
    emit(encI(mipsIsaPkg::ADDI, 5'd1, 5'd0, 16'(lfsrBits(16))));
    emit(encI(mipsIsaPkg::ADDI, 5'd2, 5'd0, 16'(lfsrBits(16))));
    emit(encI(mipsIsaPkg::ADDI, 5'd3, 5'd1, 16'(lfsrBits(16))));
    // r5 = -7
    emit(encI(mipsIsaPkg::ADDI, 5'd5, 5'd0, 16'hfff9));
    emit(encR(mipsIsaPkg::ADD, 5'd6, 5'd1, 5'd2));
    emit(encR(mipsIsaPkg::SUB, 5'd7, 5'd1, 5'd2));
    emit(encR(mipsIsaPkg::AND, 5'd8, 5'd2, 5'd3));
    emit(encR(mipsIsaPkg::OR, 5'd9, 5'd2, 5'd3));
    emit(encR(mipsIsaPkg::SLT, 5'd10, 5'd5, 5'd1));
    emit(encR(mipsIsaPkg::SLT, 5'd11, 5'd1, 5'd5));
    emit(encR(mipsIsaPkg::SLT, 5'd12, 5'd5, 5'd5));
    releaseReset();
    runSteps(11);
    endTest("arith");
  endtask

  task automatic testMemory();
    beginTest();
    emit(encI(mipsIsaPkg::ADDI, 5'd1, 5'd0, 16'h1234));
    emit(encI(mipsIsaPkg::ADDI, 5'd2, 5'd0, 16'hff9c));
    emit(encI(mipsIsaPkg::ADDI, 5'd3, 5'd0, 16'h0040));
    emit(encI(mipsIsaPkg::SW, 5'd1, 5'd0, 16'd8));
    // base register plus offset, word 17
    emit(encI(mipsIsaPkg::SW, 5'd2, 5'd3, 16'd4));
    emit(encI(mipsIsaPkg::LW, 5'd4, 5'd0, 16'd8));
    emit(encI(mipsIsaPkg::LW, 5'd5, 5'd3, 16'd4));
    // untouched word, fill value
    emit(encI(mipsIsaPkg::LW, 5'd6, 5'd0, 16'd16));
    emit(encR(mipsIsaPkg::ADD, 5'd7, 5'd4, 5'd5));
    releaseReset();
    runSteps(9);
    endTest("memory");
  endtask

  task automatic testBranch();
    beginTest();
    emit(encI(mipsIsaPkg::ADDI, 5'd1, 5'd0, 16'd3));
    emit(encI(mipsIsaPkg::ADDI, 5'd2, 5'd0, 16'd3));
    emit(encI(mipsIsaPkg::ADDI, 5'd3, 5'd0, 16'd4));
    // not taken
    emit(encI(mipsIsaPkg::BEQ, 5'd3, 5'd1, 16'd5));
    // taken, skips two
    emit(encI(mipsIsaPkg::BEQ, 5'd2, 5'd1, 16'd2));
    emit(encI(mipsIsaPkg::ADDI, 5'd4, 5'd0, 16'd1));
    emit(encI(mipsIsaPkg::ADDI, 5'd5, 5'd0, 16'd2));
    emit(encI(mipsIsaPkg::ADDI, 5'd6, 5'd0, 16'd9));
    // backward, -5 words to index 4
    emit(encI(mipsIsaPkg::BEQ, 5'd0, 5'd0, 16'hfffb));
    releaseReset();
    runSteps(9);
    endTest("branch");
  endtask

  task automatic testJumps();
    beginTest();
    emit(encJ(mipsIsaPkg::J, 3));
    emit(encI(mipsIsaPkg::ADDI, 5'd1, 5'd0, 16'd1));
    emit(encI(mipsIsaPkg::ADDI, 5'd2, 5'd0, 16'd2));
    // link is 20, index 5
    emit(encJ(mipsIsaPkg::JAL, 8));
    emit(encI(mipsIsaPkg::ADDI, 5'd3, 5'd0, 16'd4));
    emit(encI(mipsIsaPkg::ADDI, 5'd4, 5'd0, 16'd5));
    progLen = 8;
    emit(encI(mipsIsaPkg::ADDI, 5'd5, 5'd0, 16'd7));
    emit(encR(mipsIsaPkg::JR, 5'd0, 5'd31, 5'd0));
    releaseReset();
    runSteps(6);
    endTest("jumps");
  endtask

  task automatic testRegZero();
    beginTest();
    emit(encI(mipsIsaPkg::ADDI, 5'd1, 5'd0, 16'h0055));
    emit(encI(mipsIsaPkg::ADDI, 5'd0, 5'd0, 16'h0077));
    emit(encR(mipsIsaPkg::ADD, 5'd0, 5'd1, 5'd1));
    // r0 still zero, result is r1
    emit(encR(mipsIsaPkg::ADD, 5'd2, 5'd0, 5'd1));
    emit(encR(mipsIsaPkg::OR, 5'd3, 5'd0, 5'd0));
    releaseReset();
    runSteps(5);
    endTest("regzero");
  endtask

  // ======================================================================
  // main sequence and watchdog
  // ======================================================================
  initial begin
    rst           = 1'b0;
    reloadMem     = 1'b0;
    lfsrState     = 32'h6429_51da;
    errorCount    = 0;
    errorsAtStart = 0;
    testCount     = 0;
    progLen       = 0;
    shadowPc      = `RESET_VECTOR;
    @(posedge clk);
    #5;
    testReset();
    testArith();
    testMemory();
    testBranch();
    testJumps();
    testRegZero();
    $display("tests run %0d, failing checks %0d", testCount, errorCount);
    if (errorCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // 64 cycles per test plus margin
  initial begin
    repeat (NumTests * 64 + 10) @(posedge clk);
    $display("watchdog expired before the tests completed");
    $display("Something failed");
    $finish;
  end

endmodule
